//--- filelist.f
hw/cmat_pkg.sv
hw/cmat_issue.sv
hw/cadd_lane.sv
hw/cmat_collect.sv
hw/complex_matrix_add.sv
testbench/tb_complex_matrix_add.sv

//--- Makefile
TB_TOP := tb_complex_matrix_add

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --Mdir obj_dir \
		--top-module $(TB_TOP) -f filelist.f

run: build
	./obj_dir/V$(TB_TOP) | tee sim.log
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module complex_matrix_add \
		hw/cmat_pkg.sv hw/cmat_issue.sv hw/cadd_lane.sv \
		hw/cmat_collect.sv hw/complex_matrix_add.sv

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_complex_matrix_add.sv
module tb_complex_matrix_add;
  timeunit 1ns;
  timeprecision 1ps;
  import cmat_pkg::*;

  typedef logic [LANES*4-1:0][COMP_W-1:0] opnd_t;
  typedef logic [LANES*2-1:0][COMP_W-1:0] res_t;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic     clk;
  logic     rst_n;
  logic     flush;
  logic     in_valid;
  logic     in_ready;
  cplx_op_e op;
  opnd_t    operands;
  logic     out_valid;
  logic     out_ready;
  res_t     result;
  logic     busy;

  // Accepted vectors still owed by the DUT
  // Oldest at the front
  cplx_op_e op_q[$];
  opnd_t    opnd_q[$];

  int   errors = 0;
  int   checks = 0;
  int   outputs = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  int   test_err_start = 0;
  logic stall_q = 1'b0;
  res_t held_q;
  logic bp_done;

  complex_matrix_add i_complex_matrix_add (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .op_i        (op),
    .operands_i  (operands),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .busy_o      (busy)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected row from signed component arithmetic
  // Only the low COMP_W bits are kept
  function automatic res_t cplx_ref(cplx_op_e f_op, opnd_t f_opnd);
    res_t res;
    int   a_re;
    int   a_im;
    int   b_re;
    int   b_im;
    int   re;
    int   im;
    for (int i = 0; i < LANES; i++) begin
      a_re = int'($signed(f_opnd[4*i]));
      a_im = int'($signed(f_opnd[4*i+1]));
      b_re = int'($signed(f_opnd[4*i+2]));
      b_im = int'($signed(f_opnd[4*i+3]));
      if (f_op == OP_SUB) begin
        re = a_re - b_re;
        im = a_im - b_im;
      end else begin
        re = a_re + b_re;
        im = a_im + b_im;
      end
      // Truncation is the wrap modulo 2^16
      res[2*i]   = re[COMP_W-1:0];
      res[2*i+1] = im[COMP_W-1:0];
    end
    return res;
  endfunction

  function automatic opnd_t random_operands();
    opnd_t v;
    for (int w = 0; w < LANES*4; w++) begin
      v[w] = COMP_W'($urandom);
    end
    return v;
  endfunction

  // Same four components in every element
  function automatic opnd_t fill_operands(logic [COMP_W-1:0] a_re, logic [COMP_W-1:0] a_im,
                                          logic [COMP_W-1:0] b_re, logic [COMP_W-1:0] b_im);
    opnd_t v;
    for (int i = 0; i < LANES; i++) begin
      v[4*i]   = a_re;
      v[4*i+1] = a_im;
      v[4*i+2] = b_re;
      v[4*i+3] = b_im;
    end
    return v;
  endfunction

  task automatic check_result(res_t exp_res, res_t got_res);
    checks++;
    for (int i = 0; i < LANES; i++) begin
      if (got_res[2*i] !== exp_res[2*i]) begin
        errors++;
        $display("Error: result_o element %0d real expected 0x%04h, got 0x%04h",
                 i, exp_res[2*i], got_res[2*i]);
      end
      if (got_res[2*i+1] !== exp_res[2*i+1]) begin
        errors++;
        $display("Error: result_o element %0d imag expected 0x%04h, got 0x%04h",
                 i, exp_res[2*i+1], got_res[2*i+1]);
      end
    end
  endtask

  // Comparing process
  // Reads pre-edge values on each rising edge
  always @(posedge clk) begin
    cplx_op_e exp_op;
    opnd_t    exp_opnd;
    if (rst_n) begin
      // Stalled row must survive the edge untouched
      if (stall_q && !out_valid) begin
        errors++;
        $display("Error: out_valid_o expected 0x1, got 0x0 while stalled");
      end else if (stall_q && result !== held_q) begin
        errors++;
        $display("Error: result_o expected 0x%h, got 0x%h while stalled", held_q, result);
      end
      if (out_valid && out_ready) begin
        outputs++;
        if (op_q.size() == 0) begin
          errors++;
          $display("Output transfer with no vector outstanding");
        end else begin
          exp_op   = op_q.pop_front();
          exp_opnd = opnd_q.pop_front();
          check_result(cplx_ref(exp_op, exp_opnd), result);
        end
      end
      // Flush drops everything in flight
      // A vector taken on this edge is dropped too
      if (flush) begin
        op_q.delete();
        opnd_q.delete();
      end else if (in_valid && in_ready) begin
        op_q.push_back(op);
        opnd_q.push_back(operands);
      end
      stall_q = out_valid && !out_ready && !flush;
      held_q  = result;
    end else begin
      stall_q = 1'b0;
    end
  end

  task automatic idle(int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  // Hold the current input until the edge that takes it
  task automatic wait_accept();
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    while (!taken && n < WAIT_LIMIT) begin
      @(posedge clk);
      taken = in_ready;
      n++;
    end
    if (!taken) begin
      errors++;
      $display("Timeout: input vector was never accepted");
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_vector(cplx_op_e v_op, opnd_t v_opnd);
    in_valid = 1'b1;
    op       = v_op;
    operands = v_opnd;
    wait_accept();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained(string what);
    int n;
    n = 0;
    while ((op_q.size() != 0 || busy) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (op_q.size() != 0 || busy) begin
      errors++;
      $display("Timeout: %s did not drain, %0d vectors outstanding", what, op_q.size());
    end
  endtask

  task automatic check_count(int got, int expected);
    if (got != expected) begin
      errors++;
      $display("Error: output count expected 0x%0h, got 0x%0h", expected, got);
    end
  endtask

  task automatic end_test(string name);
    if (errors == test_err_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  initial begin
    int n;
    int out_before;
    rst_n     = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    op        = OP_ADD;
    operands  = '0;
    out_ready = 1'b1;
    void'($urandom(21385));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle pipeline after reset
    if (in_ready !== 1'b1) begin
      errors++;
      $display("Error: in_ready_o expected 0x1, got 0x%h", in_ready);
    end
    if (out_valid !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("Error: out_valid_o/busy_o expected 0x0/0x0, got 0x%h/0x%h", out_valid, busy);
    end
    end_test("reset_state");

    // Wrap at both ends of the range, then a random stream
    out_before = outputs;
    send_vector(OP_ADD, fill_operands(16'h7FFF, 16'h8000, 16'h0001, 16'h8000));
    send_vector(OP_SUB, fill_operands(16'h8000, 16'h7FFF, 16'h0001, 16'hFFFF));
    repeat (40) send_vector(($urandom % 2) ? OP_SUB : OP_ADD, random_operands());
    wait_drained("random stream");
    check_count(outputs - out_before, 42);
    end_test("random_add_sub");

    // Count falling edges until the row shows up
    in_valid = 1'b1;
    op       = OP_SUB;
    operands = random_operands();
    wait_accept();
    n = 0;
    do begin
      @(negedge clk);
      in_valid = 1'b0;
      n++;
    end while (!out_valid && n < WAIT_LIMIT);
    if (n != 3) begin
      errors++;
      $display("Error: out_valid_o latency expected 0x3, got 0x%0h", n);
    end
    wait_drained("latency vector");
    end_test("latency");

    // Random stalls downstream and random gaps upstream
    out_before = outputs;
    bp_done    = 1'b0;
    fork
      begin
        for (int k = 0; k < 60; k++) begin
          idle($urandom % 3);
          send_vector(($urandom % 2) ? OP_SUB : OP_ADD, random_operands());
        end
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(negedge clk);
          out_ready = ($urandom % 3) != 0;
        end
      end
    join
    out_ready = 1'b1;
    wait_drained("back-pressure stream");
    check_count(outputs - out_before, 60);
    end_test("back_pressure");

    // Fill all three stages, then flush
    out_ready = 1'b0;
    repeat (3) send_vector(OP_ADD, random_operands());
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    if (busy !== 1'b0 || out_valid !== 1'b0) begin
      errors++;
      $display("Error: busy_o/out_valid_o expected 0x0/0x0, got 0x%h/0x%h", busy, out_valid);
    end
    out_ready  = 1'b1;
    out_before = outputs;
    repeat (8) send_vector(($urandom % 2) ? OP_SUB : OP_ADD, random_operands());
    wait_drained("post-flush stream");
    check_count(outputs - out_before, 8);
    end_test("flush");

    $display("Tests: %0d passed, %0d failed; rows checked: %0d; errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- hw/complex_matrix_add.sv
module complex_matrix_add (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  logic                                               flush_i,
  // Input handshake
  input  logic                                               in_valid_i,
  output logic                                               in_ready_o,
  input  cmat_pkg::cplx_op_e                                 op_i,
  // Per element {b_im, b_re, a_im, a_re}
  input  logic [cmat_pkg::LANES*4-1:0][cmat_pkg::COMP_W-1:0] operands_i,
  // Output handshake
  output logic                                               out_valid_o,
  input  logic                                               out_ready_i,
  // Per element {im, re}
  output logic [cmat_pkg::LANES*2-1:0][cmat_pkg::COMP_W-1:0] result_o,
  // Any stage holds a vector
  output logic                                               busy_o
);
  import cmat_pkg::*;

  logic                             lane_valid;
  cplx_op_e                         lane_op;
  logic [LANES*4-1:0][COMP_W-1:0]   lane_operands;
  logic [LANES-1:0]                 lane_ready;
  logic                             all_ready;
  logic [LANES-1:0]                 lane_res_valid;
  logic [LANES*2-1:0][COMP_W-1:0]   lane_res;
  logic [LANES-1:0]                 lane_busy;
  logic                             coll_ready;
  logic                             issue_busy;
  logic                             coll_busy;

  // Issue releases only when every lane can take the vector
  assign all_ready = &lane_ready;

  cmat_issue i_cmat_issue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .op_i            (op_i),
    .operands_i      (operands_i),
    .lane_valid_o    (lane_valid),
    .lane_op_o       (lane_op),
    .lane_operands_o (lane_operands),
    .all_ready_i     (all_ready),
    .busy_o          (issue_busy)
  );

  for (genvar i = 0; i < LANES; i++) begin : lane_gen
    cadd_lane i_cadd_lane (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush_i),
      .valid_i     (lane_valid),
      .ready_o     (lane_ready[i]),
      .op_i        (lane_op),
      .a_re_i      (lane_operands[4*i]),
      .a_im_i      (lane_operands[4*i+1]),
      .b_re_i      (lane_operands[4*i+2]),
      .b_im_i      (lane_operands[4*i+3]),
      .valid_o     (lane_res_valid[i]),
      .out_ready_i (coll_ready),
      // Packed at 2i and 2i+1, no overlap between lanes
      .re_o        (lane_res[2*i]),
      .im_o        (lane_res[2*i+1]),
      .busy_o      (lane_busy[i])
    );
  end

  cmat_collect i_cmat_collect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .lane_valid_i (lane_res_valid),
    .lane_res_i   (lane_res),
    .lane_ready_o (coll_ready),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .busy_o       (coll_busy)
  );

  assign busy_o = issue_busy || (|lane_busy) || coll_busy;

endmodule

//--- hw/cmat_collect.sv
module cmat_collect (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  logic                                               flush_i,
  // Results from the lanes
  input  logic [cmat_pkg::LANES-1:0]                         lane_valid_i,
  input  logic [cmat_pkg::LANES*2-1:0][cmat_pkg::COMP_W-1:0] lane_res_i,
  // One ready shared by all lanes
  output logic                                               lane_ready_o,
  // Downstream handshake
  output logic                                               out_valid_o,
  input  logic                                               out_ready_i,
  output logic [cmat_pkg::LANES*2-1:0][cmat_pkg::COMP_W-1:0] result_o,
  output logic                                               busy_o
);

  logic all_valid;
  logic free;

  // Load only a complete row
  assign all_valid = &lane_valid_i;

  // Output register empty or drained on this edge
  assign free = !out_valid_o || out_ready_i;

  // High exactly on the load edge
  assign lane_ready_o = all_valid && free;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      out_valid_o <= 1'b0;
    end else if (free) begin
      out_valid_o <= all_valid;
    end
  end

  // Whole row captured in one go
  always_ff @(posedge clk_i) begin
    if (lane_ready_o) begin
      result_o <= lane_res_i;
    end
  end

  assign busy_o = out_valid_o;

  // Downstream sees the same row until it takes it
  a_coll_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o)
  );

endmodule

//--- hw/cadd_lane.sv
module cadd_lane (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  // Operand handshake from the issue stage
  input  logic                          valid_i,
  output logic                          ready_o,
  input  cmat_pkg::cplx_op_e            op_i,
  input  logic [cmat_pkg::COMP_W-1:0]   a_re_i,
  input  logic [cmat_pkg::COMP_W-1:0]   a_im_i,
  input  logic [cmat_pkg::COMP_W-1:0]   b_re_i,
  input  logic [cmat_pkg::COMP_W-1:0]   b_im_i,
  // Result handshake towards the collector
  output logic                          valid_o,
  input  logic                          out_ready_i,
  output logic [cmat_pkg::COMP_W-1:0]   re_o,
  output logic [cmat_pkg::COMP_W-1:0]   im_o,
  output logic                          busy_o
);
  import cmat_pkg::*;

  logic                 valid_q;
  logic [COMP_W-1:0]    re_d;
  logic [COMP_W-1:0]    im_d;
  logic [COMP_W-1:0]    re_q;
  logic [COMP_W-1:0]    im_q;

  // Two's complement add or subtract
  // Carry out of the top bit is dropped, so the result wraps
  always_comb begin
    if (op_i == OP_SUB) begin
      re_d = a_re_i - b_re_i;
      im_d = a_im_i - b_im_i;
    end else begin
      re_d = a_re_i + b_re_i;
      im_d = a_im_i + b_im_i;
    end
  end

  // Register empty or being drained this cycle
  assign ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // In-flight result dropped
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Result words only move on an operand transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      re_q <= re_d;
      im_q <= im_d;
    end
  end

  assign valid_o = valid_q;
  assign re_o    = re_q;
  assign im_o    = im_q;
  assign busy_o  = valid_q;

  // A held result only leaves through a transfer or a flush
  a_lane_valid_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !out_ready_i && !flush_i |=> valid_o
  );

endmodule

//--- hw/cmat_issue.sv
module cmat_issue (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          flush_i,
  // Upstream handshake
  input  logic                                          in_valid_i,
  output logic                                          in_ready_o,
  input  cmat_pkg::cplx_op_e                            op_i,
  input  logic [cmat_pkg::LANES*4-1:0][cmat_pkg::COMP_W-1:0] operands_i,
  // Broadcast to all lanes
  output logic                                          lane_valid_o,
  output cmat_pkg::cplx_op_e                            lane_op_o,
  output logic [cmat_pkg::LANES*4-1:0][cmat_pkg::COMP_W-1:0] lane_operands_o,
  // AND of every lane ready
  input  logic                                          all_ready_i,
  output logic                                          busy_o
);
  import cmat_pkg::*;

  logic                                 valid_q;
  cplx_op_e                             op_q;
  logic [LANES*4-1:0][COMP_W-1:0]       operands_q;
  logic                                 accept;

  // Entry free, or every lane takes it on this edge
  assign in_ready_o = !valid_q || all_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  // Valid flag, flush wins over any transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload, loaded only on an input transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q       <= op_i;
      operands_q <= operands_i;
    end
  end

  // Same vector and opcode to every lane
  assign lane_valid_o    = valid_q;
  assign lane_op_o       = op_q;
  assign lane_operands_o = operands_q;
  assign busy_o          = valid_q;

  // Lanes see a steady vector until all of them take it
  a_issue_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    lane_valid_o && !all_ready_i |=> $stable(lane_operands_o) && $stable(lane_op_o)
  );

endmodule

//--- hw/cmat_pkg.sv
package cmat_pkg;

  // Complex elements per vector, one row of the matrix
  localparam int LANES = 16;

  // Width of one real or imaginary component
  // Signed two's complement, results wrap modulo 2^COMP_W
  localparam int COMP_W = 16;

  // Input vector word order per element i:
  //   4i   a_re
  //   4i+1 a_im
  //   4i+2 b_re
  //   4i+3 b_im
  // Result vector word order per element i:
  //   2i   real part
  //   2i+1 imaginary part

  // Lane operation, applied to both components
  typedef enum logic {
    // result = a + b
    OP_ADD = 1'b0,
    // result = a - b
    OP_SUB = 1'b1
  } cplx_op_e;

endpackage
